//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f armCore.f --top-module armCoreTb -o simArmCore

run: build
	./obj_dir/simArmCore 2>&1 | tee run.log
	@if grep -q "sim failed" run.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "sim passed" run.log

lint:
	verilator --lint-only --timing -f armCore.f --top-module armCoreTb
	verilator --lint-only logic/armPkg.sv logic/regFile.sv logic/executeUnit.sv \
		logic/memoryAlign.sv logic/controller.sv logic/hazardUnit.sv \
		logic/datapath.sv logic/armCore.sv --top-module armCore

clean:
	rm -rf obj_dir run.log

//--- armCore.f
logic/armPkg.sv
logic/regFile.sv
logic/executeUnit.sv
logic/memoryAlign.sv
logic/controller.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/armCore.sv
testbench/clockGen.sv
testbench/armCoreTb.sv

//--- logic/armCore.sv
`timescale 1ns/1ps

module armCore (
  input  logic           clk,
  input  logic           reset,
  output armPkg::wordT   instrAddr,
  input  armPkg::wordT   instr,
  output logic           wbCyc,
  output logic           wbStb,
  output logic           wbWe,
  output armPkg::wordT   wbAdr,
  output armPkg::wordT   wbDatOut,
  output logic [3:0]     wbSel,
  input  armPkg::wordT   wbDatIn,
  input  logic           wbAck,
  output armPkg::retireT retire
);
  import armPkg::*;

  wordT     instrD;
  execCtrlT ctrlE;
  memCtrlT  ctrlM;
  wbCtrlT   ctrlW;
  regIdxT   readAddrA, readAddrB, readAddrAE, readAddrBE;
  flagsT    flagsE, flagsCur;
  fwdSelT   fwdA, fwdB;
  logic     condPassed, branchTaken, busWait;
  logic     stallF, stallD, stallE, stallM, stallW;
  logic     flushD, flushE, flushW;

  // Wishbone classic, one transfer per memory-stage access
  assign wbCyc = ctrlM.memRead || ctrlM.memWrite;
  assign wbStb = wbCyc;
  assign wbWe = ctrlM.memWrite;
  assign busWait = wbCyc && !wbAck;

  datapath u_datapath (
    .clk(clk), .reset(reset), .instr(instr), .instrAddr(instrAddr),
    .instrD(instrD), .ctrlE(ctrlE), .ctrlM(ctrlM), .ctrlW(ctrlW),
    .readAddrA(readAddrA), .readAddrB(readAddrB), .flagsCur(flagsCur),
    .fwdA(fwdA), .fwdB(fwdB), .branchTaken(branchTaken),
    .stallF(stallF), .stallD(stallD), .stallE(stallE), .stallM(stallM),
    .stallW(stallW), .flushD(flushD), .flagsE(flagsE), .condPassed(condPassed),
    .busAdr(wbAdr), .busDatOut(wbDatOut), .busSel(wbSel), .busDatIn(wbDatIn),
    .retire(retire)
  );

  // Byte offset for W comes off the bus address
  controller u_controller (
    .clk(clk), .reset(reset), .instrD(instrD),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushW(flushW), .condPassed(condPassed),
    .flagsE(flagsE), .byteOffsetM(wbAdr[1:0]),
    .ctrlE(ctrlE), .ctrlM(ctrlM), .ctrlW(ctrlW),
    .readAddrA(readAddrA), .readAddrB(readAddrB),
    .readAddrAE(readAddrAE), .readAddrBE(readAddrBE),
    .flagsCur(flagsCur), .branchTaken(branchTaken)
  );

  hazardUnit u_hazardUnit (
    .readAddrAD(readAddrA), .readAddrBD(readAddrB),
    .readAddrAE(readAddrAE), .readAddrBE(readAddrBE),
    .ctrlE(ctrlE), .ctrlM(ctrlM), .ctrlW(ctrlW),
    .branchTaken(branchTaken), .busWait(busWait),
    .fwdA(fwdA), .fwdB(fwdB),
    .stallF(stallF), .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushD(flushD), .flushE(flushE), .flushW(flushW)
  );

endmodule

//--- logic/armPkg.sv
package armPkg;

  // ==============================
  // Widths that carry a meaning
  // ==============================
  // Data, address or instruction
  typedef logic [31:0] wordT;
  // Register number, 15 is the PC
  typedef logic [3:0] regIdxT;
  // N Z C V with N in the top bit
  typedef logic [3:0] flagsT;

  // ==============================
  // Enums
  // ==============================
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluRsb, aluAnd, aluOrr, aluEor, aluBic, aluMov, aluMvn
  } aluOpT;

  // Same encoding as instruction bits 6:5
  typedef enum logic [1:0] {shiftLsl, shiftLsr, shiftAsr, shiftRor} shiftTypeT;

  typedef enum logic [1:0] {fwdRegFile, fwdMem, fwdWb} fwdSelT;

  typedef enum logic {resultAlu, resultLoad} resultSrcT;

  // ==============================
  // Stage control structs
  // ==============================
  typedef struct packed {
    aluOpT     aluOp;
    logic      setFlags;
    logic      immSrc;
    shiftTypeT shiftType;
    // Rotation times two for immediates
    logic [4:0] shiftAmount;
    logic [3:0] cond;
    logic      isBranch;
    logic      memWrite;
    logic      memRead;
    logic      byteAccess;
    logic      regWrite;
    resultSrcT resultSrc;
    regIdxT    rd;
  } execCtrlT;

  typedef struct packed {
    logic      memWrite;
    logic      memRead;
    logic      byteAccess;
    logic      regWrite;
    resultSrcT resultSrc;
    regIdxT    rd;
  } memCtrlT;

  typedef struct packed {
    logic      regWrite;
    resultSrcT resultSrc;
    regIdxT    rd;
    logic      byteAccess;
    logic [1:0] byteOffset;
  } wbCtrlT;

  // One writeback as seen from outside
  typedef struct packed {
    logic   valid;
    wordT   pc;
    regIdxT rd;
    wordT   data;
  } retireT;

  // ==============================
  // Constants
  // ==============================
  localparam wordT pcResetC = 32'h0000_0000;
  localparam wordT pcStepC = 32'd4;
  localparam wordT pcReadOffsetC = 32'd8;
  // Class 11 decodes to all controls off
  localparam wordT bubbleInstrC = 32'h0C00_0000;

endpackage

//--- logic/controller.sv
`timescale 1ns/1ps

module controller (
  input  logic             clk,
  input  logic             reset,
  input  armPkg::wordT     instrD,
  input  logic             stallE,
  input  logic             stallM,
  input  logic             stallW,
  input  logic             flushE,
  input  logic             flushW,
  input  logic             condPassed,
  input  armPkg::flagsT    flagsE,
  input  logic [1:0]       byteOffsetM,
  output armPkg::execCtrlT ctrlE,
  output armPkg::memCtrlT  ctrlM,
  output armPkg::wbCtrlT   ctrlW,
  output armPkg::regIdxT   readAddrA,
  output armPkg::regIdxT   readAddrB,
  output armPkg::regIdxT   readAddrAE,
  output armPkg::regIdxT   readAddrBE,
  output armPkg::flagsT    flagsCur,
  output logic             branchTaken
);
  import armPkg::*;

  execCtrlT ctrlD;
  memCtrlT  ctrlMNext;

  // ==============================
  // Decode
  // ==============================
  always_comb begin
    ctrlD = '0;
    ctrlD.cond = instrD[31:28];
    ctrlD.rd = instrD[15:12];
    readAddrA = instrD[19:16];
    readAddrB = instrD[3:0];
    case (instrD[27:26])
      // Data processing
      2'b00: begin
        ctrlD.immSrc = instrD[25];
        ctrlD.setFlags = instrD[20];
        ctrlD.regWrite = 1'b1;
        if (instrD[25]) begin
          ctrlD.shiftAmount = {instrD[11:8], 1'b0};
        end else begin
          ctrlD.shiftType = shiftTypeT'(instrD[6:5]);
          ctrlD.shiftAmount = instrD[11:7];
        end
        case (instrD[24:21])
          4'b0000: ctrlD.aluOp = aluAnd;
          4'b0001: ctrlD.aluOp = aluEor;
          4'b0010: ctrlD.aluOp = aluSub;
          4'b0011: ctrlD.aluOp = aluRsb;
          4'b0100: ctrlD.aluOp = aluAdd;
          4'b1100: ctrlD.aluOp = aluOrr;
          4'b1101: ctrlD.aluOp = aluMov;
          4'b1110: ctrlD.aluOp = aluBic;
          4'b1111: ctrlD.aluOp = aluMvn;
          // CMP only sets flags
          4'b1010: begin
            ctrlD.aluOp = aluSub;
            ctrlD.setFlags = 1'b1;
            ctrlD.regWrite = 1'b0;
          end
          default: begin
            ctrlD.setFlags = 1'b0;
            ctrlD.regWrite = 1'b0;
          end
        endcase
      end
      // LDR, STR, LDRB, STRB with immediate offset, U picks the sign
      2'b01: begin
        ctrlD.immSrc = 1'b1;
        ctrlD.aluOp = instrD[23] ? aluAdd : aluSub;
        ctrlD.byteAccess = instrD[22];
        ctrlD.memRead = instrD[20];
        ctrlD.memWrite = !instrD[20];
        ctrlD.regWrite = instrD[20];
        ctrlD.resultSrc = instrD[20] ? resultLoad : resultAlu;
        // Store data comes through port B
        readAddrB = instrD[15:12];
      end
      // B, target is PC+8 plus the offset
      2'b10: begin
        ctrlD.immSrc = 1'b1;
        ctrlD.isBranch = instrD[25];
        ctrlD.aluOp = aluAdd;
        readAddrA = 4'd15;
      end
      default: ctrlD.regWrite = 1'b0;
    endcase
  end

  // ==============================
  // Control pipeline
  // ==============================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      ctrlE <= '0;
      readAddrAE <= '0;
      readAddrBE <= '0;
    end else if (!stallE) begin
      ctrlE <= ctrlD;
      readAddrAE <= readAddrA;
      readAddrBE <= readAddrB;
    end
  end

  // Failed condition turns the instruction into a bubble from M on
  always_comb begin
    ctrlMNext.memWrite = ctrlE.memWrite && condPassed;
    ctrlMNext.memRead = ctrlE.memRead && condPassed;
    ctrlMNext.byteAccess = ctrlE.byteAccess;
    ctrlMNext.regWrite = ctrlE.regWrite && condPassed;
    ctrlMNext.resultSrc = ctrlE.resultSrc;
    ctrlMNext.rd = ctrlE.rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlM <= '0;
    end else if (!stallM) begin
      ctrlM <= ctrlMNext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flushW) begin
      ctrlW <= '0;
    end else if (!stallW) begin
      ctrlW <= {ctrlM.regWrite, ctrlM.resultSrc, ctrlM.rd, ctrlM.byteAccess, byteOffsetM};
    end
  end

  // NZCV written at the end of execute
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsCur <= '0;
    end else if (ctrlE.setFlags && condPassed && !stallE) begin
      flagsCur <= flagsE;
    end
  end

  assign branchTaken = ctrlE.isBranch && condPassed;

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ps

module datapath (
  input  logic             clk,
  input  logic             reset,
  input  armPkg::wordT     instr,
  output armPkg::wordT     instrAddr,
  output armPkg::wordT     instrD,
  input  armPkg::execCtrlT ctrlE,
  input  armPkg::memCtrlT  ctrlM,
  input  armPkg::wbCtrlT   ctrlW,
  input  armPkg::regIdxT   readAddrA,
  input  armPkg::regIdxT   readAddrB,
  input  armPkg::flagsT    flagsCur,
  input  armPkg::fwdSelT   fwdA,
  input  armPkg::fwdSelT   fwdB,
  input  logic             branchTaken,
  input  logic             stallF,
  input  logic             stallD,
  input  logic             stallE,
  input  logic             stallM,
  input  logic             stallW,
  input  logic             flushD,
  output armPkg::flagsT    flagsE,
  output logic             condPassed,
  output armPkg::wordT     busAdr,
  output armPkg::wordT     busDatOut,
  output logic [3:0]       busSel,
  input  armPkg::wordT     busDatIn,
  output armPkg::retireT   retire
);
  import armPkg::*;

  wordT pcF, pcD, pcE, pcM, pcW;
  wordT rdAD, rdBD, immD;
  logic [63:0] rotWideD;
  wordT rdAE, rdBE, immE, srcAE, writeDataE, srcBE, aluResultE;
  wordT aluOutM, writeDataM;
  wordT aluOutW, loadRawW, loadDataW, resultW;

  function automatic wordT bypass(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  // ==============================
  // Fetch
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= pcResetC;
    end else if (!stallF) begin
      pcF <= branchTaken ? aluResultE : pcF + pcStepC;
    end
  end

  assign instrAddr = pcF;

  // ==============================
  // Decode
  // ==============================
  always_ff @(posedge clk) begin
    if (reset || flushD) begin
      instrD <= bubbleInstrC;
    end else if (!stallD) begin
      instrD <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) pcD <= pcF;
  end

  regFile u_regFile (
    .clk(clk),
    .reset(reset),
    .writeEnable(ctrlW.regWrite),
    .readAddrA(readAddrA),
    .readAddrB(readAddrB),
    .writeAddr(ctrlW.rd),
    .writeData(resultW),
    .pcPlus8(pcD + pcReadOffsetC),
    .readDataA(rdAD),
    .readDataB(rdBD)
  );

  // Rotate right by twice the 4-bit field
  assign rotWideD = {2{24'b0, instrD[7:0]}} >> {instrD[11:8], 1'b0};

  // Immediate by class: rotated, 12-bit offset, branch offset
  always_comb begin
    case (instrD[27:26])
      2'b00:   immD = rotWideD[31:0];
      2'b01:   immD = {20'b0, instrD[11:0]};
      default: immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
    endcase
  end

  // ==============================
  // Execute
  // ==============================
  // While held, keep the bypassed operands since W drains to a bubble
  always_ff @(posedge clk) begin
    if (!stallE) begin
      rdAE <= rdAD;
      rdBE <= rdBD;
      immE <= immD;
      pcE <= pcD;
    end else begin
      rdAE <= srcAE;
      rdBE <= writeDataE;
    end
  end

  assign srcAE = bypass(fwdA, rdAE, aluOutM, resultW);
  assign writeDataE = bypass(fwdB, rdBE, aluOutM, resultW);
  assign srcBE = ctrlE.immSrc ? immE : writeDataE;

  executeUnit u_executeUnit (
    .srcA(srcAE),
    .srcB(srcBE),
    .ctrl(ctrlE),
    .flagsIn(flagsCur),
    .result(aluResultE),
    .flagsOut(flagsE),
    .condPassed(condPassed)
  );

  // ==============================
  // Memory
  // ==============================
  always_ff @(posedge clk) begin
    if (!stallM) begin
      aluOutM <= aluResultE;
      writeDataM <= writeDataE;
      pcM <= pcE;
    end
  end

  assign busAdr = aluOutM;

  memoryAlign u_memoryAlign (
    .storeData(writeDataM),
    .address(aluOutM),
    .byteAccess(ctrlM.byteAccess),
    .busData(busDatOut),
    .byteSel(busSel),
    .loadRaw(loadRawW),
    .loadOffset(ctrlW.byteOffset),
    .loadByte(ctrlW.byteAccess),
    .loadData(loadDataW)
  );

  // ==============================
  // Writeback
  // ==============================
  // Read data is taken in the ack cycle
  always_ff @(posedge clk) begin
    if (!stallW) begin
      aluOutW <= aluOutM;
      loadRawW <= busDatIn;
      pcW <= pcM;
    end
  end

  assign resultW = (ctrlW.resultSrc == resultLoad) ? loadDataW : aluOutW;

  always_comb begin
    retire.valid = ctrlW.regWrite;
    retire.pc = pcW;
    retire.rd = ctrlW.rd;
    retire.data = resultW;
  end

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
  input  armPkg::wordT     srcA,
  input  armPkg::wordT     srcB,
  input  armPkg::execCtrlT ctrl,
  input  armPkg::flagsT    flagsIn,
  output armPkg::wordT     result,
  output armPkg::flagsT    flagsOut,
  output logic             condPassed
);
  import armPkg::*;

  logic [32:0] leftWide, rightWide, arithWide;
  logic [63:0] rotWide;
  wordT shifted, opX, opY;
  logic shiftCarry, carryIn, arith;
  logic [32:0] sum;
  logic flagN, flagZ, flagC, flagV;

  assign {flagN, flagZ, flagC, flagV} = flagsIn;

  // ==============================
  // Barrel shifter
  // ==============================
  // Extra bit catches the last bit shifted out
  assign leftWide  = {1'b0, srcB} << ctrl.shiftAmount;
  assign rightWide = {srcB, 1'b0} >> ctrl.shiftAmount;
  assign arithWide = $signed({srcB, 1'b0}) >>> ctrl.shiftAmount;
  assign rotWide   = {srcB, srcB} >> ctrl.shiftAmount;

  always_comb begin
    shifted = srcB;
    shiftCarry = flagC;
    if (ctrl.immSrc) begin
      // Already rotated in decode, C follows bit 31 when rotated
      if (ctrl.shiftAmount != '0) shiftCarry = srcB[31];
    end else if (ctrl.shiftAmount == '0) begin
      // Zero amount means #32 for LSR and ASR, RRX for ROR
      case (ctrl.shiftType)
        shiftLsr: begin
          shifted = '0;
          shiftCarry = srcB[31];
        end
        shiftAsr: begin
          shifted = {32{srcB[31]}};
          shiftCarry = srcB[31];
        end
        shiftRor: begin
          shifted = {flagC, srcB[31:1]};
          shiftCarry = srcB[0];
        end
        default: shiftCarry = flagC;
      endcase
    end else begin
      case (ctrl.shiftType)
        shiftLsr: {shifted, shiftCarry} = rightWide;
        shiftAsr: {shifted, shiftCarry} = arithWide;
        shiftRor: {shifted, shiftCarry} = {rotWide[31:0], rightWide[0]};
        default:  {shiftCarry, shifted} = leftWide;
      endcase
    end
  end

  // ==============================
  // ALU
  // ==============================
  // Subtracts become X + ~Y + 1
  always_comb begin
    opX = srcA;
    opY = shifted;
    carryIn = 1'b0;
    if (ctrl.aluOp == aluSub) begin
      opY = ~shifted;
      carryIn = 1'b1;
    end else if (ctrl.aluOp == aluRsb) begin
      opX = shifted;
      opY = ~srcA;
      carryIn = 1'b1;
    end
  end

  assign sum = {1'b0, opX} + {1'b0, opY} + {32'b0, carryIn};

  always_comb begin
    arith = 1'b0;
    result = shifted;
    case (ctrl.aluOp)
      aluAdd, aluSub, aluRsb: begin
        result = sum[31:0];
        arith = 1'b1;
      end
      aluAnd:  result = srcA & shifted;
      aluOrr:  result = srcA | shifted;
      aluEor:  result = srcA ^ shifted;
      aluBic:  result = srcA & ~shifted;
      aluMvn:  result = ~shifted;
      default: result = shifted;
    endcase
  end

  // Logical ops take C from the shifter and keep V
  assign flagsOut[3] = result[31];
  assign flagsOut[2] = (result == '0);
  assign flagsOut[1] = arith ? sum[32] : shiftCarry;
  assign flagsOut[0] = arith ? ((opX[31] == opY[31]) && (sum[31] != opX[31])) : flagV;

  // ==============================
  // Condition check
  // ==============================
  always_comb begin
    case (ctrl.cond)
      4'h0: condPassed = flagZ;
      4'h1: condPassed = !flagZ;
      4'h2: condPassed = flagC;
      4'h3: condPassed = !flagC;
      4'h4: condPassed = flagN;
      4'h5: condPassed = !flagN;
      4'h6: condPassed = flagV;
      4'h7: condPassed = !flagV;
      4'h8: condPassed = flagC && !flagZ;
      4'h9: condPassed = !flagC || flagZ;
      4'hA: condPassed = (flagN == flagV);
      4'hB: condPassed = (flagN != flagV);
      4'hC: condPassed = !flagZ && (flagN == flagV);
      4'hD: condPassed = flagZ || (flagN != flagV);
      4'hE: condPassed = 1'b1;
      default: condPassed = 1'b0;  // NV
    endcase
  end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  input  armPkg::regIdxT   readAddrAD,
  input  armPkg::regIdxT   readAddrBD,
  input  armPkg::regIdxT   readAddrAE,
  input  armPkg::regIdxT   readAddrBE,
  input  armPkg::execCtrlT ctrlE,
  input  armPkg::memCtrlT  ctrlM,
  input  armPkg::wbCtrlT   ctrlW,
  input  logic             branchTaken,
  input  logic             busWait,
  output armPkg::fwdSelT   fwdA,
  output armPkg::fwdSelT   fwdB,
  output logic             stallF,
  output logic             stallD,
  output logic             stallE,
  output logic             stallM,
  output logic             stallW,
  output logic             flushD,
  output logic             flushE,
  output logic             flushW
);
  import armPkg::*;

  logic loadUse;

  // Youngest producer wins, PC reads never bypass
  function automatic fwdSelT pickSource(regIdxT src, memCtrlT m, wbCtrlT w);
    if (src != 4'd15 && m.regWrite && (m.rd == src)) return fwdMem;
    if (src != 4'd15 && w.regWrite && (w.rd == src)) return fwdWb;
    return fwdRegFile;
  endfunction

  assign fwdA = pickSource(readAddrAE, ctrlM, ctrlW);
  assign fwdB = pickSource(readAddrBE, ctrlM, ctrlW);

  // Load in E feeding the instruction in D
  assign loadUse = ctrlE.memRead && ((ctrlE.rd == readAddrAD) || (ctrlE.rd == readAddrBD));

  // Bus wait freezes F to M and drains W
  assign stallF = busWait || loadUse;
  assign stallD = busWait || loadUse;
  assign stallE = busWait;
  assign stallM = busWait;
  assign stallW = 1'b0;  // W never holds
  assign flushW = busWait;

  // Branch redirect waits for the bus to finish
  assign flushD = branchTaken && !busWait;
  assign flushE = (branchTaken || loadUse) && !busWait;

endmodule

//--- logic/memoryAlign.sv
`timescale 1ns/1ps

module memoryAlign (
  input  armPkg::wordT storeData,
  input  armPkg::wordT address,
  input  logic         byteAccess,
  output armPkg::wordT busData,
  output logic [3:0]   byteSel,
  input  armPkg::wordT loadRaw,
  input  logic [1:0]   loadOffset,
  input  logic         loadByte,
  output armPkg::wordT loadData
);
  import armPkg::*;

  logic [7:0] laneByte;

  // ==============================
  // Store side
  // ==============================
  // Byte store puts the low byte on every lane
  assign busData = byteAccess ? {4{storeData[7:0]}} : storeData;

  // One select per byte lane, little endian
  always_comb begin
    if (byteAccess) begin
      byteSel = 4'b0001 << address[1:0];
    end else begin
      byteSel = 4'b1111;
    end
  end

  // ==============================
  // Load side
  // ==============================
  assign laneByte = loadRaw[8 * loadOffset +: 8];

  // Zero extended byte or whole word
  assign loadData = loadByte ? {24'b0, laneByte} : loadRaw;

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic          clk,
  input  logic          reset,
  input  logic          writeEnable,
  input  armPkg::regIdxT readAddrA,
  input  armPkg::regIdxT readAddrB,
  input  armPkg::regIdxT writeAddr,
  input  armPkg::wordT  writeData,
  input  armPkg::wordT  pcPlus8,
  output armPkg::wordT  readDataA,
  output armPkg::wordT  readDataB
);
  import armPkg::*;

  // R0 to R14, R15 lives in the PC
  wordT regs [0:14];

  // R15 reads the PC, a same-cycle write passes straight through
  function automatic wordT readPort(regIdxT addr);
    if (addr == 4'd15) begin
      return pcPlus8;
    end else if (writeEnable && (addr == writeAddr)) begin
      return writeData;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeAddr != 4'd15)) begin
      regs[writeAddr] <= writeData;
    end
  end

  always_comb begin
    readDataA = readPort(readAddrA);
    readDataB = readPort(readAddrB);
  end

endmodule

//--- testbench/armCoreTb.sv
`timescale 1ns/1ps

module armCoreTb;
  import armPkg::*;

  localparam int romWords = 64;
  // Condition NV so filler words never execute
  localparam wordT idleInstr = 32'hF000_0000;

  logic clk, reset;
  wordT instrAddr, instr, wbAdr, wbDatOut, wbDatIn;
  logic wbCyc, wbStb, wbWe, wbAck;
  logic [3:0] wbSel;
  retireT retire;

  // ==============================
  // Program and store tables
  // ==============================
  wordT rom [0:romWords-1];
  wordT dataMem [0:63];
  retireT expRetire [$];
  wordT storeAdr [$];
  wordT storeDat [$];
  logic [3:0] storeSel [$];
  int progLen = 0;

  int errorCount = 0;
  int retireIdx = 0;
  int storeIdx = 0;
  int cycleCount = 0;
  int timeoutLimit = 0;
  int drainCount = 0;
  logic runDone = 1'b0;
  logic timedOut = 1'b0;

  // Bus transfer in progress
  logic busBusy = 1'b0;
  int waitLeft = 0;
  wordT heldAdr, heldDat;
  logic heldWe;
  logic [3:0] heldSel;

  clockGen u_clockGen (.clk(clk), .reset(reset));

  armCore u_armCore (
    .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatOut(wbDatOut), .wbSel(wbSel), .wbDatIn(wbDatIn), .wbAck(wbAck),
    .retire(retire)
  );

  // Instruction ROM answers in the same cycle
  assign instr = rom[instrAddr[7:2]];

  // Entry goes at index progLen and its PC is the byte address
  task automatic addEntry(wordT word, logic retires, regIdxT rd, wordT data);
    retireT r;
    rom[progLen] = word;
    if (retires) begin
      r.valid = 1'b1;
      r.pc = progLen * 4;
      r.rd = rd;
      r.data = data;
      expRetire.push_back(r);
    end
    progLen++;
  endtask

  task automatic addStore(wordT adr, wordT data, logic [3:0] sel);
    storeAdr.push_back(adr);
    storeDat.push_back(data);
    storeSel.push_back(sel);
  endtask

  // ==============================
  // Checks
  // ==============================
  task automatic checkRetire(retireT got, retireT exp);
    if (got.pc !== exp.pc) begin
      errorCount++;
      $display("[FAIL] %0t retire.pc got %h expected %h", $time, got.pc, exp.pc);
    end
    if (got.rd !== exp.rd) begin
      errorCount++;
      $display("[FAIL] %0t retire.rd got %0d expected %0d", $time, got.rd, exp.rd);
    end
    if (got.data !== exp.data) begin
      errorCount++;
      $display("[FAIL] %0t retire.data got %h expected %h", $time, got.data, exp.data);
    end
  endtask

  task automatic checkBusWrite(wordT gotAdr, wordT gotDat, logic [3:0] gotSel, int idx);
    if (gotAdr !== storeAdr[idx]) begin
      errorCount++;
      $display("[FAIL] %0t wbAdr got %h expected %h", $time, gotAdr, storeAdr[idx]);
    end
    if (gotDat !== storeDat[idx]) begin
      errorCount++;
      $display("[FAIL] %0t wbDatOut got %h expected %h", $time, gotDat, storeDat[idx]);
    end
    if (gotSel !== storeSel[idx]) begin
      errorCount++;
      $display("[FAIL] %0t wbSel got %b expected %b", $time, gotSel, storeSel[idx]);
    end
  endtask

  // Finish the held transfer and raise ack
  task automatic completeTransfer();
    if (heldWe) begin
      if (storeIdx < storeAdr.size()) begin
        checkBusWrite(heldAdr, heldDat, heldSel, storeIdx);
      end else begin
        errorCount++;
        $display("Unexpected bus write to %h at %0t", heldAdr, $time);
      end
      storeIdx++;
      for (int b = 0; b < 4; b++) begin
        if (heldSel[b]) dataMem[heldAdr[7:2]][8*b +: 8] = heldDat[8*b +: 8];
      end
    end else begin
      wbDatIn = dataMem[heldAdr[7:2]];
    end
    wbAck = 1'b1;
    busBusy = 1'b0;
  endtask

  // ==============================
  // Monitor and memory model
  // ==============================
  always @(negedge clk) begin
    if (reset) begin
      // Reset keeps the bus idle and the retire port quiet
      if (wbCyc !== 1'b0 || wbWe !== 1'b0 || retire.valid !== 1'b0) begin
        errorCount++;
        $display("Bus or retire port active during reset at %0t", $time);
      end
    end else if (!runDone) begin
      cycleCount++;
      if (retire.valid) begin
        if (retireIdx < expRetire.size()) begin
          checkRetire(retire, expRetire[retireIdx]);
        end else begin
          errorCount++;
          $display("Extra retire of r%0d at %0t", retire.rd, $time);
        end
        retireIdx++;
      end
      // Ack lasts one cycle
      if (wbAck) begin
        wbAck = 1'b0;
      end else if (wbCyc) begin
        if (!wbStb) begin
          errorCount++;
          $display("Strobe low with cycle high at %0t", $time);
        end
        if (!busBusy) begin
          busBusy = 1'b1;
          waitLeft = $urandom % 4;
          heldAdr = wbAdr;
          heldDat = wbDatOut;
          heldWe = wbWe;
          heldSel = wbSel;
        end else if (wbAdr !== heldAdr || wbDatOut !== heldDat || wbWe !== heldWe ||
                     wbSel !== heldSel) begin
          errorCount++;
          $display("Bus outputs changed before ack at %0t", $time);
        end
        if (waitLeft == 0) completeTransfer();
        else waitLeft--;
      end else if (busBusy) begin
        errorCount++;
        $display("Cycle dropped before ack at %0t", $time);
        busBusy = 1'b0;
      end
      // Let the pipeline drain to catch stray retires
      if (retireIdx >= expRetire.size() && storeIdx >= storeAdr.size()) drainCount++;
      if (drainCount >= 8) runDone = 1'b1;
      if (cycleCount >= timeoutLimit) begin
        timedOut = 1'b1;
        runDone = 1'b1;
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    void'($urandom(39));
    wbAck = 1'b0;
    wbDatIn = '0;
    for (int i = 0; i < romWords; i++) begin
      rom[i] = idleInstr | wordT'(i);
      dataMem[i] = {8'hD0, 8'(i), 8'(~i), 8'(i * 3)};
    end
    // Columns are word, retires flag, rd and data
    addEntry(32'hE3A0_0040, 1'b1, 4'd0, 32'h0000_0040);   // MOV r0,#0x40
    addEntry(32'hE3A0_14FF, 1'b1, 4'd1, 32'hFF00_0000);   // MOV r1,#0xFF ror 8
    addEntry(32'hE081_2000, 1'b1, 4'd2, 32'hFF00_0040);   // ADD r2,r1,r0
    addEntry(32'hE042_3100, 1'b1, 4'd3, 32'hFEFF_FF40);   // SUB r3,r2,r0,LSL #2
    addEntry(32'hE1A0_4241, 1'b1, 4'd4, 32'hFFF0_0000);   // MOV r4,r1,ASR #4
    addEntry(32'hE1A0_5021, 1'b1, 4'd5, 32'h0000_0000);   // MOV r5,r1,LSR #32
    addEntry(32'hE1A0_6260, 1'b1, 4'd6, 32'h0000_0004);   // MOV r6,r0,ROR #4
    addEntry(32'hE020_7C21, 1'b1, 4'd7, 32'h0000_00BF);   // EOR r7,r0,r1,LSR #24
    addEntry(32'hE1A0_800F, 1'b1, 4'd8, 32'h20 + pcReadOffsetC);  // MOV r8,pc
    addEntry(32'hE387_9C01, 1'b1, 4'd9, 32'h0000_01BF);   // ORR r9,r7,#0x100
    addEntry(32'hE3C9_A00F, 1'b1, 4'd10, 32'h0000_01B0);  // BIC r10,r9,#0xF
    addEntry(32'hE3E0_B000, 1'b1, 4'd11, 32'hFFFF_FFFF);  // MVN r11,#0
    addEntry(32'hE260_CC01, 1'b1, 4'd12, 32'h0000_00C0);  // RSB r12,r0,#0x100
    // Flags
    addEntry(32'hE350_0040, 1'b0, 4'd0, '0);              // CMP r0,#0x40
    addEntry(32'h13A0_1001, 1'b0, 4'd0, '0);              // MOVNE skipped
    addEntry(32'h03A0_2002, 1'b1, 4'd2, 32'h0000_0002);   // MOVEQ r2,#2
    addEntry(32'hE29B_3001, 1'b1, 4'd3, 32'h0000_0000);   // ADDS r3,r11,#1
    addEntry(32'h3284_4001, 1'b0, 4'd0, '0);              // ADDCC skipped
    addEntry(32'h2280_4001, 1'b1, 4'd4, 32'h0000_0041);   // ADDCS r4,r0,#1
    // Taken branch over two slots
    addEntry(32'hEA00_0001, 1'b0, 4'd0, '0);              // B to 0x58
    addEntry(32'hE3A0_5055, 1'b0, 4'd0, '0);
    addEntry(32'hE3A0_6066, 1'b0, 4'd0, '0);
    addEntry(32'hE3A0_5077, 1'b1, 4'd5, 32'h0000_0077);   // branch target
    // Memory
    addEntry(32'hE580_9010, 1'b0, 4'd0, '0);              // STR r9,[r0,#0x10]
    addEntry(32'hE5C0_7021, 1'b0, 4'd0, '0);              // STRB r7,[r0,#0x21]
    addEntry(32'hE590_1010, 1'b1, 4'd1, 32'h0000_01BF);   // LDR r1,[r0,#0x10]
    addEntry(32'hE081_2001, 1'b1, 4'd2, 32'h0000_037E);   // ADD r2,r1,r1 load-use
    addEntry(32'hE5D0_3021, 1'b1, 4'd3, 32'h0000_00BF);   // LDRB r3,[r0,#0x21]
    addEntry(32'hE243_403F, 1'b1, 4'd4, 32'h0000_0080);   // SUB r4,r3,#0x3F
    addEntry(32'hE580_4014, 1'b0, 4'd0, '0);              // STR r4,[r0,#0x14]
    addEntry(32'hE590_C014, 1'b1, 4'd12, 32'h0000_0080);  // LDR r12,[r0,#0x14]
    addStore(32'h0000_0050, 32'h0000_01BF, 4'b1111);
    addStore(32'h0000_0061, 32'hBFBF_BFBF, 4'b0010);
    addStore(32'h0000_0054, 32'h0000_0080, 4'b1111);
    timeoutLimit = 4 * progLen + 50;

    wait (runDone);
    if (timedOut) begin
      $display("Run stopped after %0d cycles without finishing the program", cycleCount);
    end
    $display("Summary: %0d errors, %0d of %0d retires, %0d of %0d stores, timeout %0d",
             errorCount, retireIdx, expRetire.size(), storeIdx, storeAdr.size(), timedOut);
    if (errorCount == 0 && !timedOut) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);
  localparam int halfPeriodPs = 2000;
  localparam int resetCycles = 5;

  initial clk = 1'b0;

  // 4 ns period
  always #(halfPeriodPs * 1ps) clk = ~clk;

  // Reset held for five rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule
